// ==== core_types_pkg.sv ====
package core_types_pkg;

    // datapath widths.
    localparam int WORD_W = 32;
    localparam int PC_W = 32;
    localparam int PREG_W = 6;
    localparam int ROB_NUM_W = 6;

    // data memory, word addressed.
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    // word index sits above the byte offset.
    localparam int DMEM_IDX_LSB = 2;
    localparam int DMEM_IDX_MSB = DMEM_IDX_LSB + DMEM_IDX_W - 1;

    // a data word.
    typedef logic [WORD_W-1:0] word_t;

    // an instruction address.
    typedef logic [PC_W-1:0] pc_t;

    // a physical register number.
    typedef logic [PREG_W-1:0] preg_t;

    // a reorder-buffer entry.
    typedef logic [ROB_NUM_W-1:0] rob_num_t;

    // word index into data memory, address bits 9:2.
    typedef logic [DMEM_IDX_W-1:0] dmem_idx_t;

endpackage

// ==== exec_ops_pkg.sv ====
package exec_ops_pkg;

    localparam int OPTYPE_W = 4;

    // shifts take the low bits of the second operand.
    localparam int SHAMT_W = 5;

    typedef logic [OPTYPE_W-1:0] optype_t;

    // integer ALU operations.
    localparam optype_t OP_ADD = 4'd0;
    localparam optype_t OP_SUB = 4'd1;
    localparam optype_t OP_AND = 4'd2;
    localparam optype_t OP_OR = 4'd3;
    localparam optype_t OP_XOR = 4'd4;
    localparam optype_t OP_SLL = 4'd5;
    localparam optype_t OP_SRL = 4'd6;
    // signed compare, result is 1 or 0.
    localparam optype_t OP_SLT = 4'd7;

    // word load and store, lane 2 only.
    localparam optype_t OP_LW = 4'd8;
    localparam optype_t OP_SW = 4'd9;

    // true for operations that touch data memory.
    function automatic logic is_mem_op(input optype_t op);
        logic mem;
        mem = (op == OP_LW) || (op == OP_SW);
        return mem;
    endfunction

endpackage

// ==== alu_unit.sv ====
module alu_unit
    import core_types_pkg::*;
    import exec_ops_pkg::*;
(
    input  optype_t optype,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [SHAMT_W-1:0] shamt;
    logic               less;

    assign shamt = b[SHAMT_W-1:0];
    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (optype)
            OP_ADD: begin
                result = a + b;
            end
            OP_SUB: begin
                result = a - b;
            end
            OP_AND: begin
                result = a & b;
            end
            OP_OR: begin
                result = a | b;
            end
            OP_XOR: begin
                result = a ^ b;
            end
            OP_SLL: begin
                result = a << shamt;
            end
            OP_SRL: begin
                result = a >> shamt;
            end
            OP_SLT: begin
                result = word_t'(less);
            end
            // address generation for lane 2.
            OP_LW, OP_SW: begin
                result = a + b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== exec_stage.sv ====
module exec_stage
    import core_types_pkg::*;
    import exec_ops_pkg::*;
(
    // lane 0.
    input  logic     valid_0,
    input  pc_t      pc_0,
    input  optype_t  optype_0,
    input  word_t    src_a_0,
    input  word_t    src_b_0,
    input  preg_t    dest_reg_0,
    input  rob_num_t rob_num_0,

    // lane 1.
    input  logic     valid_1,
    input  pc_t      pc_1,
    input  optype_t  optype_1,
    input  word_t    src_a_1,
    input  word_t    src_b_1,
    input  preg_t    dest_reg_1,
    input  rob_num_t rob_num_1,

    // lane 2, may carry loads and stores.
    input  logic     valid_2,
    input  pc_t      pc_2,
    input  optype_t  optype_2,
    input  word_t    src_a_2,
    input  word_t    src_b_2,
    input  word_t    imm_2,
    input  preg_t    dest_reg_2,
    input  rob_num_t rob_num_2,

    output logic     ex_valid_0,
    output pc_t      ex_pc_0,
    output word_t    ex_alu_out_0,
    output preg_t    ex_dest_reg_0,
    output rob_num_t ex_rob_num_0,

    output logic     ex_valid_1,
    output pc_t      ex_pc_1,
    output word_t    ex_alu_out_1,
    output preg_t    ex_dest_reg_1,
    output rob_num_t ex_rob_num_1,

    output logic     ex_valid_2,
    output pc_t      ex_pc_2,
    output word_t    ex_alu_out_2,
    output preg_t    ex_dest_reg_2,
    output rob_num_t ex_rob_num_2,
    output optype_t  ex_optype_2,
    output word_t    ex_store_data_2
);

    word_t alu_b_2;

    // memory ops add the immediate to form the address.
    assign alu_b_2 = is_mem_op(optype_2) ? imm_2 : src_b_2;

    alu_unit alu_0_i (.optype(optype_0), .a(src_a_0), .b(src_b_0), .result(ex_alu_out_0));
    alu_unit alu_1_i (.optype(optype_1), .a(src_a_1), .b(src_b_1), .result(ex_alu_out_1));
    alu_unit alu_2_i (.optype(optype_2), .a(src_a_2), .b(alu_b_2), .result(ex_alu_out_2));

    assign ex_valid_0 = valid_0;
    assign ex_pc_0 = pc_0;
    assign ex_dest_reg_0 = dest_reg_0;
    assign ex_rob_num_0 = rob_num_0;

    assign ex_valid_1 = valid_1;
    assign ex_pc_1 = pc_1;
    assign ex_dest_reg_1 = dest_reg_1;
    assign ex_rob_num_1 = rob_num_1;

    assign ex_valid_2 = valid_2;
    assign ex_pc_2 = pc_2;
    assign ex_dest_reg_2 = dest_reg_2;
    assign ex_rob_num_2 = rob_num_2;
    assign ex_optype_2 = optype_2;
    assign ex_store_data_2 = src_b_2;

    // issue must steer loads and stores to lane 2 only.
    always_comb begin
        assert (!(valid_0 && is_mem_op(optype_0)) && !(valid_1 && is_mem_op(optype_1)))
            else $error("memory operation issued on lane 0 or 1");
    end

endmodule

// ==== ex_mem_reg.sv ====
module ex_mem_reg
    import core_types_pkg::*;
    import exec_ops_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,

    input  logic     ex_valid_0,
    input  pc_t      ex_pc_0,
    input  word_t    ex_alu_out_0,
    input  preg_t    ex_dest_reg_0,
    input  rob_num_t ex_rob_num_0,

    input  logic     ex_valid_1,
    input  pc_t      ex_pc_1,
    input  word_t    ex_alu_out_1,
    input  preg_t    ex_dest_reg_1,
    input  rob_num_t ex_rob_num_1,

    // lane 2 keeps its optype for the memory stage.
    input  logic     ex_valid_2,
    input  pc_t      ex_pc_2,
    input  word_t    ex_alu_out_2,
    input  preg_t    ex_dest_reg_2,
    input  rob_num_t ex_rob_num_2,
    input  optype_t  ex_optype_2,
    input  word_t    ex_store_data_2,

    output logic     mem_valid_0,
    output pc_t      mem_pc_0,
    output word_t    mem_alu_out_0,
    output preg_t    mem_dest_reg_0,
    output rob_num_t mem_rob_num_0,

    output logic     mem_valid_1,
    output pc_t      mem_pc_1,
    output word_t    mem_alu_out_1,
    output preg_t    mem_dest_reg_1,
    output rob_num_t mem_rob_num_1,

    output logic     mem_valid_2,
    output pc_t      mem_pc_2,
    output word_t    mem_alu_out_2,
    output preg_t    mem_dest_reg_2,
    output rob_num_t mem_rob_num_2,
    output optype_t  mem_optype_2,
    output word_t    mem_store_data_2
);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mem_valid_0 <= 1'b0;
            mem_pc_0 <= '0;
            mem_alu_out_0 <= '0;
            mem_dest_reg_0 <= '0;
            mem_rob_num_0 <= '0;

            mem_valid_1 <= 1'b0;
            mem_pc_1 <= '0;
            mem_alu_out_1 <= '0;
            mem_dest_reg_1 <= '0;
            mem_rob_num_1 <= '0;

            mem_valid_2 <= 1'b0;
            mem_pc_2 <= '0;
            mem_alu_out_2 <= '0;
            mem_dest_reg_2 <= '0;
            mem_rob_num_2 <= '0;
            mem_optype_2 <= OP_ADD;
            mem_store_data_2 <= '0;
        end else begin
            mem_valid_0 <= ex_valid_0;
            mem_pc_0 <= ex_pc_0;
            mem_alu_out_0 <= ex_alu_out_0;
            mem_dest_reg_0 <= ex_dest_reg_0;
            mem_rob_num_0 <= ex_rob_num_0;

            mem_valid_1 <= ex_valid_1;
            mem_pc_1 <= ex_pc_1;
            mem_alu_out_1 <= ex_alu_out_1;
            mem_dest_reg_1 <= ex_dest_reg_1;
            mem_rob_num_1 <= ex_rob_num_1;

            mem_valid_2 <= ex_valid_2;
            mem_pc_2 <= ex_pc_2;
            mem_alu_out_2 <= ex_alu_out_2;
            mem_dest_reg_2 <= ex_dest_reg_2;
            mem_rob_num_2 <= ex_rob_num_2;
            mem_optype_2 <= ex_optype_2;
            mem_store_data_2 <= ex_store_data_2;
        end
    end

    // nothing reaches memory stage right after reset.
    assert property (@(posedge clk) !rstn |=> !(mem_valid_0 || mem_valid_1 || mem_valid_2))
        else $error("valid set in the cycle after reset");

endmodule

// ==== mem_stage.sv ====
module mem_stage
    import core_types_pkg::*;
    import exec_ops_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,

    input  logic     mem_valid_0,
    input  pc_t      mem_pc_0,
    input  word_t    mem_alu_out_0,
    input  preg_t    mem_dest_reg_0,
    input  rob_num_t mem_rob_num_0,

    input  logic     mem_valid_1,
    input  pc_t      mem_pc_1,
    input  word_t    mem_alu_out_1,
    input  preg_t    mem_dest_reg_1,
    input  rob_num_t mem_rob_num_1,

    input  logic     mem_valid_2,
    input  pc_t      mem_pc_2,
    input  word_t    mem_alu_out_2,
    input  preg_t    mem_dest_reg_2,
    input  rob_num_t mem_rob_num_2,
    input  optype_t  mem_optype_2,
    input  word_t    mem_store_data_2,

    output logic     done_0,
    output pc_t      done_pc_0,
    output word_t    done_result_0,
    output preg_t    done_dest_reg_0,
    output rob_num_t done_rob_num_0,
    output logic     done_wb_en_0,

    output logic     done_1,
    output pc_t      done_pc_1,
    output word_t    done_result_1,
    output preg_t    done_dest_reg_1,
    output rob_num_t done_rob_num_1,
    output logic     done_wb_en_1,

    output logic     done_2,
    output pc_t      done_pc_2,
    output word_t    done_result_2,
    output preg_t    done_dest_reg_2,
    output rob_num_t done_rob_num_2,
    output logic     done_wb_en_2
);

    word_t     dmem [DMEM_WORDS];
    dmem_idx_t idx_2;
    word_t     rd_data_2;
    word_t     result_2;
    logic      store_2;

    assign idx_2 = mem_alu_out_2[DMEM_IDX_MSB:DMEM_IDX_LSB];
    assign rd_data_2 = dmem[idx_2];
    assign store_2 = mem_valid_2 && (mem_optype_2 == OP_SW);

    // loads return memory, stores and ALU ops return alu_out.
    assign result_2 = (mem_optype_2 == OP_LW) ? rd_data_2 : mem_alu_out_2;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (store_2) begin
            dmem[idx_2] <= mem_store_data_2;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            done_0 <= 1'b0;
            done_pc_0 <= '0;
            done_result_0 <= '0;
            done_dest_reg_0 <= '0;
            done_rob_num_0 <= '0;
            done_wb_en_0 <= 1'b0;

            done_1 <= 1'b0;
            done_pc_1 <= '0;
            done_result_1 <= '0;
            done_dest_reg_1 <= '0;
            done_rob_num_1 <= '0;
            done_wb_en_1 <= 1'b0;

            done_2 <= 1'b0;
            done_pc_2 <= '0;
            done_result_2 <= '0;
            done_dest_reg_2 <= '0;
            done_rob_num_2 <= '0;
            done_wb_en_2 <= 1'b0;
        end else begin
            done_0 <= mem_valid_0;
            done_pc_0 <= mem_pc_0;
            done_result_0 <= mem_alu_out_0;
            done_dest_reg_0 <= mem_dest_reg_0;
            done_rob_num_0 <= mem_rob_num_0;
            done_wb_en_0 <= 1'b1;

            done_1 <= mem_valid_1;
            done_pc_1 <= mem_pc_1;
            done_result_1 <= mem_alu_out_1;
            done_dest_reg_1 <= mem_dest_reg_1;
            done_rob_num_1 <= mem_rob_num_1;
            done_wb_en_1 <= 1'b1;

            done_2 <= mem_valid_2;
            done_pc_2 <= mem_pc_2;
            done_result_2 <= result_2;
            done_dest_reg_2 <= mem_dest_reg_2;
            done_rob_num_2 <= mem_rob_num_2;
            // stores have no register to write.
            done_wb_en_2 <= (mem_optype_2 != OP_SW);
        end
    end

    // address from execute must be word aligned.
    assert property (@(posedge clk) disable iff (!rstn)
        mem_valid_2 && is_mem_op(mem_optype_2) |-> mem_alu_out_2[DMEM_IDX_LSB-1:0] == '0)
        else $error("misaligned lane 2 memory access");

endmodule

// ==== exec_mem_top.sv ====
module exec_mem_top
    import core_types_pkg::*;
    import exec_ops_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,

    input  logic     valid_0,
    input  pc_t      pc_0,
    input  optype_t  optype_0,
    input  word_t    src_a_0,
    input  word_t    src_b_0,
    input  preg_t    dest_reg_0,
    input  rob_num_t rob_num_0,

    input  logic     valid_1,
    input  pc_t      pc_1,
    input  optype_t  optype_1,
    input  word_t    src_a_1,
    input  word_t    src_b_1,
    input  preg_t    dest_reg_1,
    input  rob_num_t rob_num_1,

    input  logic     valid_2,
    input  pc_t      pc_2,
    input  optype_t  optype_2,
    input  word_t    src_a_2,
    input  word_t    src_b_2,
    input  word_t    imm_2,
    input  preg_t    dest_reg_2,
    input  rob_num_t rob_num_2,

    output logic     done_0,
    output pc_t      done_pc_0,
    output word_t    done_result_0,
    output preg_t    done_dest_reg_0,
    output rob_num_t done_rob_num_0,
    output logic     done_wb_en_0,

    output logic     done_1,
    output pc_t      done_pc_1,
    output word_t    done_result_1,
    output preg_t    done_dest_reg_1,
    output rob_num_t done_rob_num_1,
    output logic     done_wb_en_1,

    output logic     done_2,
    output pc_t      done_pc_2,
    output word_t    done_result_2,
    output preg_t    done_dest_reg_2,
    output rob_num_t done_rob_num_2,
    output logic     done_wb_en_2
);

    // execute outputs.
    logic     ex_valid_0, ex_valid_1, ex_valid_2;
    pc_t      ex_pc_0, ex_pc_1, ex_pc_2;
    word_t    ex_alu_out_0, ex_alu_out_1, ex_alu_out_2;
    preg_t    ex_dest_reg_0, ex_dest_reg_1, ex_dest_reg_2;
    rob_num_t ex_rob_num_0, ex_rob_num_1, ex_rob_num_2;
    optype_t  ex_optype_2;
    word_t    ex_store_data_2;

    // registered, into memory stage.
    logic     mem_valid_0, mem_valid_1, mem_valid_2;
    pc_t      mem_pc_0, mem_pc_1, mem_pc_2;
    word_t    mem_alu_out_0, mem_alu_out_1, mem_alu_out_2;
    preg_t    mem_dest_reg_0, mem_dest_reg_1, mem_dest_reg_2;
    rob_num_t mem_rob_num_0, mem_rob_num_1, mem_rob_num_2;
    optype_t  mem_optype_2;
    word_t    mem_store_data_2;

    exec_stage exec_i (
        .valid_0(valid_0), .pc_0(pc_0), .optype_0(optype_0),
        .src_a_0(src_a_0), .src_b_0(src_b_0),
        .dest_reg_0(dest_reg_0), .rob_num_0(rob_num_0),
        .valid_1(valid_1), .pc_1(pc_1), .optype_1(optype_1),
        .src_a_1(src_a_1), .src_b_1(src_b_1),
        .dest_reg_1(dest_reg_1), .rob_num_1(rob_num_1),
        .valid_2(valid_2), .pc_2(pc_2), .optype_2(optype_2),
        .src_a_2(src_a_2), .src_b_2(src_b_2), .imm_2(imm_2),
        .dest_reg_2(dest_reg_2), .rob_num_2(rob_num_2),
        .ex_valid_0(ex_valid_0), .ex_pc_0(ex_pc_0), .ex_alu_out_0(ex_alu_out_0),
        .ex_dest_reg_0(ex_dest_reg_0), .ex_rob_num_0(ex_rob_num_0),
        .ex_valid_1(ex_valid_1), .ex_pc_1(ex_pc_1), .ex_alu_out_1(ex_alu_out_1),
        .ex_dest_reg_1(ex_dest_reg_1), .ex_rob_num_1(ex_rob_num_1),
        .ex_valid_2(ex_valid_2), .ex_pc_2(ex_pc_2), .ex_alu_out_2(ex_alu_out_2),
        .ex_dest_reg_2(ex_dest_reg_2), .ex_rob_num_2(ex_rob_num_2),
        .ex_optype_2(ex_optype_2), .ex_store_data_2(ex_store_data_2)
    );

    ex_mem_reg ex_mem_i (
        .clk(clk), .rstn(rstn),
        .ex_valid_0(ex_valid_0), .ex_pc_0(ex_pc_0), .ex_alu_out_0(ex_alu_out_0),
        .ex_dest_reg_0(ex_dest_reg_0), .ex_rob_num_0(ex_rob_num_0),
        .ex_valid_1(ex_valid_1), .ex_pc_1(ex_pc_1), .ex_alu_out_1(ex_alu_out_1),
        .ex_dest_reg_1(ex_dest_reg_1), .ex_rob_num_1(ex_rob_num_1),
        .ex_valid_2(ex_valid_2), .ex_pc_2(ex_pc_2), .ex_alu_out_2(ex_alu_out_2),
        .ex_dest_reg_2(ex_dest_reg_2), .ex_rob_num_2(ex_rob_num_2),
        .ex_optype_2(ex_optype_2), .ex_store_data_2(ex_store_data_2),
        .mem_valid_0(mem_valid_0), .mem_pc_0(mem_pc_0), .mem_alu_out_0(mem_alu_out_0),
        .mem_dest_reg_0(mem_dest_reg_0), .mem_rob_num_0(mem_rob_num_0),
        .mem_valid_1(mem_valid_1), .mem_pc_1(mem_pc_1), .mem_alu_out_1(mem_alu_out_1),
        .mem_dest_reg_1(mem_dest_reg_1), .mem_rob_num_1(mem_rob_num_1),
        .mem_valid_2(mem_valid_2), .mem_pc_2(mem_pc_2), .mem_alu_out_2(mem_alu_out_2),
        .mem_dest_reg_2(mem_dest_reg_2), .mem_rob_num_2(mem_rob_num_2),
        .mem_optype_2(mem_optype_2), .mem_store_data_2(mem_store_data_2)
    );

    mem_stage mem_i (
        .clk(clk), .rstn(rstn),
        .mem_valid_0(mem_valid_0), .mem_pc_0(mem_pc_0), .mem_alu_out_0(mem_alu_out_0),
        .mem_dest_reg_0(mem_dest_reg_0), .mem_rob_num_0(mem_rob_num_0),
        .mem_valid_1(mem_valid_1), .mem_pc_1(mem_pc_1), .mem_alu_out_1(mem_alu_out_1),
        .mem_dest_reg_1(mem_dest_reg_1), .mem_rob_num_1(mem_rob_num_1),
        .mem_valid_2(mem_valid_2), .mem_pc_2(mem_pc_2), .mem_alu_out_2(mem_alu_out_2),
        .mem_dest_reg_2(mem_dest_reg_2), .mem_rob_num_2(mem_rob_num_2),
        .mem_optype_2(mem_optype_2), .mem_store_data_2(mem_store_data_2),
        .done_0(done_0), .done_pc_0(done_pc_0), .done_result_0(done_result_0),
        .done_dest_reg_0(done_dest_reg_0), .done_rob_num_0(done_rob_num_0),
        .done_wb_en_0(done_wb_en_0),
        .done_1(done_1), .done_pc_1(done_pc_1), .done_result_1(done_result_1),
        .done_dest_reg_1(done_dest_reg_1), .done_rob_num_1(done_rob_num_1),
        .done_wb_en_1(done_wb_en_1),
        .done_2(done_2), .done_pc_2(done_pc_2), .done_result_2(done_result_2),
        .done_dest_reg_2(done_dest_reg_2), .done_rob_num_2(done_rob_num_2),
        .done_wb_en_2(done_wb_en_2)
    );

endmodule

// ==== tb_exec_mem.sv ====
module tb_exec_mem
    import core_types_pkg::*;
    import exec_ops_pkg::*;
;

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 8;
    localparam int DIRECTED_CYCLES = 40;
    localparam int RAND_CYCLES = 400;
    localparam int WATCHDOG_CYCLES = RST_CYCLES + DIRECTED_CYCLES + RAND_CYCLES + 20;

    typedef struct {
        pc_t      pc;
        word_t    result;
        preg_t    dest_reg;
        rob_num_t rob_num;
        logic     wb_en;
        int       due;
    } exp_t;

    logic     clk, rstn;
    logic     valid_0, valid_1, valid_2;
    pc_t      pc_0, pc_1, pc_2;
    optype_t  optype_0, optype_1, optype_2;
    word_t    src_a_0, src_a_1, src_a_2;
    word_t    src_b_0, src_b_1, src_b_2;
    word_t    imm_2;
    preg_t    dest_reg_0, dest_reg_1, dest_reg_2;
    rob_num_t rob_num_0, rob_num_1, rob_num_2;
    logic     done_0, done_1, done_2;
    pc_t      done_pc_0, done_pc_1, done_pc_2;
    word_t    done_result_0, done_result_1, done_result_2;
    preg_t    done_dest_reg_0, done_dest_reg_1, done_dest_reg_2;
    rob_num_t done_rob_num_0, done_rob_num_1, done_rob_num_2;
    logic     done_wb_en_0, done_wb_en_1, done_wb_en_2;

    int    seed;
    int    seq = 0;
    int    cyc = 0;
    exp_t  exp_q [3][$];
    word_t model_mem [DMEM_WORDS];

    // directed operands, three lanes per round.
    word_t dir_a [6] = '{32'h7fff_ffff, 32'h0000_0003, 32'h8000_0001,
                         32'h8000_0000, 32'hf0f0_f0f0, 32'hffff_ffff};
    word_t dir_b [6] = '{32'h8000_0001, 32'h0000_0005, 32'h0000_003f,
                         32'h0000_0001, 32'h0000_0020, 32'h0000_001f};

    exec_mem_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // integer result by operation type.
    function automatic word_t expected_alu(input optype_t op, input word_t a, input word_t b);
        word_t r;
        case (op)
            OP_ADD: r = a + b;
            OP_SUB: r = a + ~b + 32'd1;
            OP_AND: r = a & b;
            OP_OR: r = a | b;
            OP_XOR: r = a ^ b;
            OP_SLL: r = a << b[4:0];
            OP_SRL: r = a >> b[4:0];
            OP_SLT: begin
                if (a[31] != b[31]) begin
                    r = {31'd0, a[31]};
                end else begin
                    r = {31'd0, a < b};
                end
            end
            default: r = 32'd0;
        endcase
        return r;
    endfunction

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    // small values now and then, so shifts see short amounts.
    function automatic word_t rand_operand();
        word_t w;
        w = rand_word();
        if (w[31:30] == 2'd0) begin
            w = w & 32'h0000_003f;
        end
        return w;
    endfunction

    function automatic int pending();
        return exp_q[0].size() + exp_q[1].size() + exp_q[2].size();
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        valid_0 <= 1'b0;
        valid_1 <= 1'b0;
        valid_2 <= 1'b0;
    endtask

    // issue one operation and record its completion.
    task automatic drive_lane(input logic [1:0] lane, input optype_t op, input word_t a,
                              input word_t b, input word_t imm);
        exp_t      e;
        pc_t       pc;
        preg_t     dr;
        rob_num_t  rn;
        word_t     addr;
        dmem_idx_t idx;
        pc = 32'h0040_0000 + pc_t'(seq) * 32'd4;
        dr = preg_t'(rand_word());
        rn = rob_num_t'(seq);
        seq++;
        addr = a + imm;
        idx = addr[DMEM_IDX_MSB:DMEM_IDX_LSB];
        e.pc = pc;
        e.dest_reg = dr;
        e.rob_num = rn;
        e.wb_en = (op != OP_SW);
        // valid at this edge, done shows after two more edges.
        e.due = cyc + 3;
        if (op == OP_LW) begin
            e.result = model_mem[idx];
        end else if (op == OP_SW) begin
            e.result = addr;
            model_mem[idx] = b;
        end else begin
            e.result = expected_alu(op, a, b);
        end
        exp_q[lane].push_back(e);
        case (lane)
            2'd0: begin
                valid_0 <= 1'b1;
                pc_0 <= pc;
                optype_0 <= op;
                src_a_0 <= a;
                src_b_0 <= b;
                dest_reg_0 <= dr;
                rob_num_0 <= rn;
            end
            2'd1: begin
                valid_1 <= 1'b1;
                pc_1 <= pc;
                optype_1 <= op;
                src_a_1 <= a;
                src_b_1 <= b;
                dest_reg_1 <= dr;
                rob_num_1 <= rn;
            end
            default: begin
                valid_2 <= 1'b1;
                pc_2 <= pc;
                optype_2 <= op;
                src_a_2 <= a;
                src_b_2 <= b;
                imm_2 <= imm;
                dest_reg_2 <= dr;
                rob_num_2 <= rn;
            end
        endcase
    endtask

    task automatic random_issue();
        word_t r;
        word_t base;
        word_t off;
        r = rand_word();
        if (r[1:0] != 2'd0) begin
            drive_lane(2'd0, optype_t'(r[4:2]), rand_operand(), rand_operand(), 32'd0);
        end
        if (r[6:5] != 2'd0) begin
            drive_lane(2'd1, optype_t'(r[9:7]), rand_operand(), rand_operand(), 32'd0);
        end
        if (r[11:10] != 2'd0) begin
            // aligned, inside the first 64 words.
            base = {25'd0, r[16:12], 2'b00};
            off = {25'd0, r[21:17], 2'b00};
            case (r[23:22])
                2'd0: drive_lane(2'd2, OP_SW, base, rand_word(), off);
                2'd1: drive_lane(2'd2, OP_LW, base, rand_word(), off);
                default: begin
                    drive_lane(2'd2, optype_t'(r[26:24]), rand_operand(), rand_operand(),
                               rand_word());
                end
            endcase
        end
    endtask

    task automatic check_lane(input logic [1:0] lane, input logic d, input pc_t pc,
                              input word_t res, input preg_t dr, input rob_num_t rn,
                              input logic wb);
        exp_t e;
        if (d === 1'b1) begin
            if (exp_q[lane].size() == 0) begin
                report_failure($sformatf("lane %0d completed with nothing outstanding", lane));
            end else begin
                e = exp_q[lane].pop_front();
                compare($sformatf("done_cycle_%0d", lane), cyc, e.due);
                compare($sformatf("done_pc_%0d", lane), pc, e.pc);
                compare($sformatf("done_result_%0d", lane), res, e.result);
                compare($sformatf("done_dest_reg_%0d", lane), 32'(dr), 32'(e.dest_reg));
                compare($sformatf("done_rob_num_%0d", lane), 32'(rn), 32'(e.rob_num));
                compare($sformatf("done_wb_en_%0d", lane), 32'(wb), 32'(e.wb_en));
            end
        end else if (d !== 1'b0) begin
            report_failure($sformatf("done on lane %0d is unknown", lane));
        end else if (exp_q[lane].size() != 0 && exp_q[lane][0].due <= cyc) begin
            report_failure($sformatf("lane %0d missed a completion", lane));
        end
    endtask

    // outputs are stable at the falling edge.
    initial begin
        forever begin
            @(negedge clk);
            cyc++;
            if (rstn) begin
                check_lane(2'd0, done_0, done_pc_0, done_result_0, done_dest_reg_0,
                           done_rob_num_0, done_wb_en_0);
                check_lane(2'd1, done_1, done_pc_1, done_result_1, done_dest_reg_1,
                           done_rob_num_1, done_wb_en_1);
                check_lane(2'd2, done_2, done_pc_2, done_result_2, done_dest_reg_2,
                           done_rob_num_2, done_wb_en_2);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("simulation ran past the watchdog limit");
    end

    initial begin
        seed = 32'hd364;
        rstn = 1'b0;
        {valid_0, valid_1, valid_2} = 3'b000;
        {pc_0, pc_1, pc_2} = '0;
        {optype_0, optype_1, optype_2} = '0;
        {src_a_0, src_a_1, src_a_2} = '0;
        {src_b_0, src_b_1, src_b_2} = '0;
        imm_2 = '0;
        {dest_reg_0, dest_reg_1, dest_reg_2} = '0;
        {rob_num_0, rob_num_1, rob_num_2} = '0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            model_mem[i] = 32'd0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        rstn <= 1'b1;

        // idle, done must stay low.
        repeat (4) next_cycle();

        // every ALU op on every lane, back to back.
        for (int r = 0; r < 2; r++) begin
            for (int op = 0; op < 8; op++) begin
                next_cycle();
                drive_lane(2'd0, optype_t'(op), dir_a[r * 3], dir_b[r * 3], 32'd0);
                drive_lane(2'd1, optype_t'(op), dir_a[r * 3 + 1], dir_b[r * 3 + 1], 32'd0);
                drive_lane(2'd2, optype_t'(op), dir_a[r * 3 + 2], dir_b[r * 3 + 2],
                           32'h0000_0ffc);
            end
        end
        next_cycle();

        // store then load of the same word, two splits of the address.
        next_cycle();
        drive_lane(2'd2, OP_SW, 32'h0000_0100, 32'hdead_beef, 32'h0000_0010);
        drive_lane(2'd0, OP_ADD, 32'h0000_0001, 32'h0000_0002, 32'd0);
        next_cycle();
        drive_lane(2'd2, OP_LW, 32'h0000_0110, 32'h0000_0000, 32'h0000_0000);
        drive_lane(2'd1, OP_XOR, 32'h5a5a_5a5a, 32'hffff_0000, 32'd0);
        next_cycle();
        drive_lane(2'd2, OP_SW, 32'h0000_0080, 32'h1234_5678, 32'hffff_fffc);
        next_cycle();
        drive_lane(2'd2, OP_LW, 32'h0000_0070, 32'h0000_0000, 32'h0000_000c);

        // never written since reset.
        next_cycle();
        drive_lane(2'd2, OP_LW, 32'h0000_03f0, 32'h0000_0000, 32'h0000_0000);
        repeat (4) next_cycle();

        for (int i = 0; i < RAND_CYCLES; i++) begin
            next_cycle();
            random_issue();
        end
        next_cycle();

        // last completions are due two edges after the final issue.
        for (int i = 0; i < 8 && pending() != 0; i++) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);

        if (pending() != 0) begin
            report_failure("expected completions still outstanding at end of test");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// ==== src.f ====
core_types_pkg.sv
exec_ops_pkg.sv
alu_unit.sv
exec_stage.sv
ex_mem_reg.sv
mem_stage.sv
exec_mem_top.sv
tb_exec_mem.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_exec_mem
RTL_TOP    := exec_mem_top
FILELIST   := src.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
